// File: design/SramGeometryPkg.sv
/*
 * SRAM geometry package.
 * Array depth, line layout and the macro bank slicing of the line memory.
 */
package SramGeometryPkg;

    localparam int lineCount = 128;              // Entries in the array and in each macro.
    localparam int lineIndexBits = 7;
    localparam int lineBits = 256;
    localparam int lineBytes = 32;

    // Bank k holds line bits 64k to 64k+63.
    localparam int bankCount = 4;
    localparam int bankBits = 64;
    localparam int bankBytes = 8;

    typedef logic [lineIndexBits-1:0] LineIndex;
    typedef logic [lineBits-1:0] LineData;
    typedef logic [lineBytes-1:0] LineByteEnable;

endpackage : SramGeometryPkg

// File: design/WishbonePkg.sv
/*
 * Wishbone slave package.
 * Bus widths of the word port and the slave state encoding.
 */
package WishbonePkg;

    localparam int wbAddrBits = 10;              // Line index on top, word lane below.
    localparam int wbDataBits = 32;
    localparam int wbSelBits = 4;
    localparam int wbWordIndexBits = 3;
    localparam int wbWordsPerLine = 8;

    typedef enum logic [1:0] {
        Idle,                                    // Waiting for a strobe.
        Access,                                  // Array returns the line.
        Respond                                  // Ack is high.
    } WbSlaveState;

endpackage : WishbonePkg

// File: design/SramPortIf.sv
/*
 * One access port of the line array.
 * Index, byte enables and write data go in, the registered read line comes out.
 */
`timescale 1ns/1ps

interface SramPortIf
    import SramGeometryPkg::*;
();

    LineIndex      index;
    LineByteEnable byteEnable;                   // Zero means a plain read.
    LineData       writeData;
    LineData       readData;                     // Valid one cycle after index.

    modport requester (
        output index,
        output byteEnable,
        output writeData,
        input  readData
    );

    modport array (
        input  index,
        input  byteEnable,
        input  writeData,
        output readData
    );

endinterface : SramPortIf

// File: design/SramMacroBank.sv
/*
 * Dual-port 128x64 macro model.
 * Two read-first ports with byte write enables and registered read data.
 */
`timescale 1ns/1ps

module SramMacroBank
    import SramGeometryPkg::*;
(
    input  logic                  clk,
    input  LineIndex              aIndex,
    input  logic [bankBytes-1:0]  aByteWe,
    input  logic [bankBits-1:0]   aWriteData,
    output logic [bankBits-1:0]   aReadData,
    input  LineIndex              bIndex,
    input  logic [bankBytes-1:0]  bByteWe,
    input  logic [bankBits-1:0]   bWriteData,
    output logic [bankBits-1:0]   bReadData
);

    logic [bankBits-1:0] mem [lineCount];

    // Port b wins a byte that both ports write.
    always_ff @(posedge clk) begin
        for (int i = 0; i < bankBytes; i++) begin
            if (aByteWe[i]) begin
                mem[aIndex][i*8 +: 8] <= aWriteData[i*8 +: 8];
            end
            if (bByteWe[i]) begin
                mem[bIndex][i*8 +: 8] <= bWriteData[i*8 +: 8];
            end
        end
        aReadData <= mem[aIndex];                // Old contents on a same-port write.
        bReadData <= mem[bIndex];
    end

endmodule : SramMacroBank

// File: design/SramLineArray.sv
/*
 * Line array of four macro banks.
 * Two 256-bit read/write ports, with the other port's same-cycle write
 * merged into the next read data.
 */
`timescale 1ns/1ps

module SramLineArray
    import SramGeometryPkg::*;
(
    input logic   clk,
    SramPortIf.array portA,
    SramPortIf.array portB
);

    LineData       bankReadA;
    LineData       bankReadB;

    // Bytes written by the other port to the line read last cycle.
    LineByteEnable fwdEnableA;
    LineByteEnable fwdEnableB;
    LineData       fwdDataA;
    LineData       fwdDataB;

    for (genvar k = 0; k < bankCount; k++) begin : gBank
        SramMacroBank bank_i (
            .clk        (clk),
            .aIndex     (portA.index),
            .aByteWe    (portA.byteEnable[k*bankBytes +: bankBytes]),
            .aWriteData (portA.writeData[k*bankBits +: bankBits]),
            .aReadData  (bankReadA[k*bankBits +: bankBits]),
            .bIndex     (portB.index),
            .bByteWe    (portB.byteEnable[k*bankBytes +: bankBytes]),
            .bWriteData (portB.writeData[k*bankBits +: bankBits]),
            .bReadData  (bankReadB[k*bankBits +: bankBits])
        );
    end

    always_ff @(posedge clk) begin
        fwdEnableA <= (portA.index == portB.index) ? portB.byteEnable : '0;
        fwdEnableB <= (portA.index == portB.index) ? portA.byteEnable : '0;
        fwdDataA <= portB.writeData;
        fwdDataB <= portA.writeData;
    end

    always_comb begin
        for (int i = 0; i < lineBytes; i++) begin
            portA.readData[i*8 +: 8] = fwdEnableA[i] ? fwdDataA[i*8 +: 8] : bankReadA[i*8 +: 8];
            portB.readData[i*8 +: 8] = fwdEnableB[i] ? fwdDataB[i*8 +: 8] : bankReadB[i*8 +: 8];
        end
    end

    // The requesters must never write one line from both sides at once.
    noDualWrite: assert property (@(posedge clk)
        ((|portA.byteEnable) && (|portB.byteEnable)) |-> (portA.index != portB.index)
    ) else $error("Both ports write line %0d in one cycle.", portA.index);

endmodule : SramLineArray

// File: design/WishboneLineSlave.sv
/*
 * Wishbone classic slave on port 0.
 * Maps 32-bit word accesses with byte selects onto line reads and byte-enabled
 * line writes; every transfer takes three cycles.
 */
`timescale 1ns/1ps

module WishboneLineSlave
    import SramGeometryPkg::*;
    import WishbonePkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [wbAddrBits-1:0]  adr,
    input  logic [wbSelBits-1:0]   sel,
    input  logic [wbDataBits-1:0]  datW,
    output logic [wbDataBits-1:0]  datR,
    output logic                   ack,
    SramPortIf.requester           mem
);

    WbSlaveState state;
    WbSlaveState nextState;

    logic                       accept;
    logic [wbWordIndexBits-1:0] wordSel;     // Lane of the accepted word.

    assign accept = (state == Idle) && cyc && stb;

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (accept) begin
                    nextState = Access;
                end
            end
            Access:  nextState = Respond;
            Respond: nextState = Idle;
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // The array sees the request in the Idle cycle that accepts it.
    assign mem.index = adr[wbAddrBits-1 -: lineIndexBits];
    assign mem.writeData = {wbWordsPerLine{datW}};

    always_comb begin
        mem.byteEnable = '0;
        if (accept && we) begin
            mem.byteEnable = LineByteEnable'(sel) << (adr[wbWordIndexBits-1:0] * wbSelBits);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wordSel <= adr[wbWordIndexBits-1:0];
        end
        if (state == Access) begin
            datR <= mem.readData[wordSel*wbDataBits +: wbDataBits];  // Line data is valid now.
        end
    end

    assign ack = (state == Respond);

    requestStable: assert property (@(posedge clk) disable iff (!rstN)
        (state != Idle) |-> ($stable(adr) && $stable(we) && $stable(sel) && $stable(datW))
    ) else $error("Master changed the request before ack.");

    ackInsideStrobe: assert property (@(posedge clk) disable iff (!rstN)
        ack |-> (cyc && stb)
    ) else $error("Ack raised without an active strobe.");

endmodule : WishboneLineSlave

// File: design/LineMemoryTop.sv
/*
 * Line memory top level.
 * Wishbone word port on array port 0, raw line port on array port 1.
 */
`timescale 1ns/1ps

module LineMemoryTop
    import SramGeometryPkg::*;
    import WishbonePkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [wbAddrBits-1:0]  wbAdr,
    input  logic [wbSelBits-1:0]   wbSel,
    input  logic [wbDataBits-1:0]  wbDatW,
    output logic [wbDataBits-1:0]  wbDatR,
    output logic                   wbAck,
    input  LineIndex               lineIndex,
    input  LineByteEnable          lineByteEnable,
    input  LineData                lineWriteData,
    output LineData                lineReadData
);

    SramPortIf wbPort ();
    SramPortIf linePort ();

    // Refill and eviction traffic goes straight to port 1.
    assign linePort.index = lineIndex;
    assign linePort.byteEnable = lineByteEnable;
    assign linePort.writeData = lineWriteData;
    assign lineReadData = linePort.readData;

    WishboneLineSlave slave_i (
        .clk  (clk),
        .rstN (rstN),
        .cyc  (wbCyc),
        .stb  (wbStb),
        .we   (wbWe),
        .adr  (wbAdr),
        .sel  (wbSel),
        .datW (wbDatW),
        .datR (wbDatR),
        .ack  (wbAck),
        .mem  (wbPort.requester)
    );

    SramLineArray array_i (
        .clk   (clk),
        .portA (wbPort.array),
        .portB (linePort.array)
    );

endmodule : LineMemoryTop

// File: sim/LineMemoryTb.sv
/*
 * Line memory testbench.
 * Runs the operations of the test file against the Wishbone and line ports
 * and checks them against a reference copy of the array.
 */
`timescale 1ns/1ps

module LineMemoryTb
    import SramGeometryPkg::*;
    import WishbonePkg::*;
();

    localparam int clkPeriod = 40;
    localparam int driveDelay = 2;
    localparam int ackLimit = 8;                 // Cycles to wait for an ack.

    logic                   clk;
    logic                   rstN;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    logic [wbAddrBits-1:0]  wbAdr;
    logic [wbSelBits-1:0]   wbSel;
    logic [wbDataBits-1:0]  wbDatW;
    logic [wbDataBits-1:0]  wbDatR;
    logic                   wbAck;
    LineIndex               lineIndex;
    LineByteEnable          lineByteEnable;
    LineData                lineWriteData;
    LineData                lineReadData;

    string       nameQ[$];
    string       opQ[$];
    logic [31:0] addrQ[$];
    logic [31:0] enQ[$];
    string       dataQ[$];
    string       expQ[$];

    LineData     refMem [lineCount];             // Expected array contents.
    logic [31:0] rngState = 32'd27119;
    bit          testsLoaded = 0;
    bit          testFailed;
    int          watchdogCycles;
    int          passCount = 0;
    int          failCount = 0;

    LineMemoryTop dut_i (
        .clk            (clk),
        .rstN           (rstN),
        .wbCyc          (wbCyc),
        .wbStb          (wbStb),
        .wbWe           (wbWe),
        .wbAdr          (wbAdr),
        .wbSel          (wbSel),
        .wbDatW         (wbDatW),
        .wbDatR         (wbDatR),
        .wbAck          (wbAck),
        .lineIndex      (lineIndex),
        .lineByteEnable (lineByteEnable),
        .lineWriteData  (lineWriteData),
        .lineReadData   (lineReadData)
    );

    always #(clkPeriod/2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Overlays the enabled bytes of a write on a stored line.
    function automatic LineData mergeLine(input LineData oldLine, input LineData newLine,
                                          input LineByteEnable en);
        LineData result;
        result = oldLine;
        for (int i = 0; i < lineBytes; i++) begin
            if (en[i]) begin
                result[i*8 +: 8] = newLine[i*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic LineByteEnable wordEnable(input logic [wbAddrBits-1:0] adr,
                                                 input logic [wbSelBits-1:0] sel);
        LineByteEnable en;
        en = '0;
        for (int b = 0; b < wbSelBits; b++) begin
            en[adr[2:0]*4 + b] = sel[b];
        end
        return en;
    endfunction

    task automatic parseData(input string s, output LineData d);
        int n;
        d = '0;
        if (s == "rand") begin
            for (int i = 0; i < lineBits/32; i++) begin
                rngState = xorshift32(rngState);
                d[i*32 +: 32] = rngState;
            end
        end else begin
            n = $sscanf(s, "%h", d);
        end
    endtask

    task automatic resolveLine(input string s, input LineData refLine, output LineData e);
        int n;
        e = refLine;
        if (s != "ref") begin
            n = $sscanf(s, "%h", e);
        end
    endtask

    task automatic resolveWord(input string s, input LineData refLine, input logic [2:0] lane,
                               output logic [31:0] w);
        int n;
        w = refLine[lane*32 +: 32];
        if (s != "ref") begin
            n = $sscanf(s, "%h", w);
        end
    endtask

    task automatic loadTests(output bit opened);
        int fd;
        int code;
        int c;
        bit done;
        string name, op, dataStr, expStr;
        logic [31:0] addr, en;
        opened = 0;
        done = 0;
        fd = $fopen("sim/memTests.txt", "r");
        if (fd != 0) begin
            opened = 1;
            while (!done) begin
                code = $fscanf(fd, "%s", name);
                if (code != 1) begin
                    done = 1;
                end else if (name.getc(0) == "#") begin
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%s %h %h %s %s", op, addr, en, dataStr, expStr);
                    if (code == 5) begin
                        nameQ.push_back(name);
                        opQ.push_back(op);
                        addrQ.push_back(addr);
                        enQ.push_back(en);
                        dataQ.push_back(dataStr);
                        expQ.push_back(expStr);
                    end else begin
                        $display("Test file entry %s is incomplete and was skipped.", name);
                        failCount++;
                        done = 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finishTest(input string name);
        if (testFailed) begin
            failCount++;
            $display("fail  %s", name);
        end else begin
            passCount++;
            $display("ok    %s", name);
        end
    endtask

    // One Wishbone transfer; the line read data after the first edge is returned too.
    task automatic wbTransfer(input string name, input logic we, input logic [wbAddrBits-1:0] adr,
                              input logic [wbSelBits-1:0] sel, input logic [wbDataBits-1:0] datW,
                              output logic [wbDataBits-1:0] datR, output LineData lineAfter);
        int steps;
        int ackStep;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbSel = sel;
        wbDatW = datW;
        ackStep = 0;
        datR = 'x;
        lineAfter = 'x;
        for (steps = 1; steps <= ackLimit && ackStep == 0; steps++) begin
            @(posedge clk);
            #(driveDelay);
            if (steps == 1) begin
                lineAfter = lineReadData;
                lineByteEnable = '0;              // A line write lasts one cycle.
            end
            if (wbAck === 1'b1) begin
                ackStep = steps;
                datR = wbDatR;
            end
        end
        if (ackStep == 0) begin
            $display("Test %s: no ack from the Wishbone slave within %0d cycles.", name, ackLimit);
            testFailed = 1;
        end else begin
            if (ackStep != 2) begin
                $display("Test %s: ack came %0d cycles after the strobe instead of 2.",
                         name, ackStep);
                testFailed = 1;
            end
            @(posedge clk);
            #(driveDelay);
            if (wbAck !== 1'b0) begin
                $display("Test %s: ack stayed high for more than one cycle.", name);
                testFailed = 1;
            end
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic lineAccess(input LineIndex idx, input LineByteEnable en, input LineData d,
                              output LineData rd);
        lineIndex = idx;
        lineByteEnable = en;
        lineWriteData = d;
        @(posedge clk);
        #(driveDelay);
        rd = lineReadData;                       // Read sampled at the edge just passed.
        lineByteEnable = '0;
    endtask

    task automatic checkResetAck();
        testFailed = 0;
        repeat (2) begin
            @(posedge clk);
            #(driveDelay);
            if (wbAck !== 1'b0) begin
                $display("Test ackAfterReset: wbAck is not low during reset.");
                testFailed = 1;
            end
        end
        rstN = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #(driveDelay);
            if (wbAck !== 1'b0) begin
                $display("Test ackAfterReset: wbAck rose before any strobe.");
                testFailed = 1;
            end
        end
        finishTest("ackAfterReset");
    endtask

    task automatic runTest(input int t);
        string name, op;
        LineData data, expLine, gotLine;
        LineIndex idx;
        logic [wbAddrBits-1:0] adr;
        logic [wbSelBits-1:0] sel;
        logic [31:0] expWord, gotWord;
        name = nameQ[t];
        op = opQ[t];
        adr = addrQ[t][wbAddrBits-1:0];
        sel = enQ[t][wbSelBits-1:0];
        idx = (op == "lineWrite" || op == "lineRead") ? addrQ[t][6:0] : adr[9:3];
        testFailed = 0;
        parseData(dataQ[t], data);
        if (op == "lineWrite") begin
            lineAccess(idx, enQ[t], data, gotLine);
            refMem[idx] = mergeLine(refMem[idx], data, enQ[t]);
        end else if (op == "lineRead") begin
            lineAccess(idx, '0, '0, gotLine);
            resolveLine(expQ[t], refMem[idx], expLine);
            if (gotLine !== expLine) begin
                $display("ERROR %s: expected %h, actual %h", name, expLine, gotLine);
                testFailed = 1;
            end
        end else if (op == "wbWrite") begin
            wbTransfer(name, 1'b1, adr, sel, data[31:0], gotWord, gotLine);
            refMem[idx] = mergeLine(refMem[idx], {8{data[31:0]}}, wordEnable(adr, sel));
        end else if (op == "wbRead" || op == "collide") begin
            if (op == "collide") begin
                lineIndex = idx;                 // Line write to the same line as the read.
                lineByteEnable = enQ[t];
                lineWriteData = data;
                refMem[idx] = mergeLine(refMem[idx], data, enQ[t]);
            end
            wbTransfer(name, 1'b0, adr, '0, '0, gotWord, gotLine);
            resolveWord(expQ[t], refMem[idx], adr[2:0], expWord);
            if (gotWord !== expWord) begin
                $display("ERROR %s: expected %h, actual %h", name, expWord, gotWord);
                testFailed = 1;
            end
        end else if (op == "collideRev") begin
            lineIndex = idx;
            lineByteEnable = '0;
            wbTransfer(name, 1'b1, adr, sel, data[31:0], gotWord, gotLine);
            refMem[idx] = mergeLine(refMem[idx], {8{data[31:0]}}, wordEnable(adr, sel));
            resolveLine(expQ[t], refMem[idx], expLine);
            if (gotLine !== expLine) begin
                $display("ERROR %s: expected %h, actual %h", name, expLine, gotLine);
                testFailed = 1;
            end
        end else begin
            $display("Test %s: unknown operation %s.", name, op);
            testFailed = 1;
        end
        finishTest(name);
    endtask

    initial begin
        wait (testsLoaded);
        #(watchdogCycles * clkPeriod);
        $display("Watchdog: the run did not finish within %0d cycles.", watchdogCycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : mainFlow
        bit opened;
        clk = 1'b0;
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbSel = '0;
        wbDatW = '0;
        lineIndex = '0;
        lineByteEnable = '0;
        lineWriteData = '0;
        loadTests(opened);
        if (!opened) begin
            $display("Could not open the test file sim/memTests.txt.");
            $display("Simulation FAILED");
            $finish;
        end else begin
            watchdogCycles = nameQ.size() * 10 + 20;
            testsLoaded = 1;
            checkResetAck();
            for (int t = 0; t < nameQ.size(); t++) begin
                runTest(t);
            end
            $display("Tests passed: %0d, failed: %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule : LineMemoryTb

// File: vlog.f
design/SramGeometryPkg.sv
design/WishbonePkg.sv
design/SramPortIf.sv
design/SramMacroBank.sv
design/SramLineArray.sv
design/WishboneLineSlave.sv
design/LineMemoryTop.sv
sim/LineMemoryTb.sv

// File: sim/memTests.txt
# Columns: name op addr en data expect, with addr, en and data in hex.
# Line ops: addr is the line index and en the 32 byte enables. Wishbone ops: addr is the word
# address and en the 4 sel bits. collide is a Wishbone read against a line write of the same
# line, collideRev a Wishbone write against a line read. "rand" data is random, "ref" expects
# the reference memory, "-" means no value.
fullWrite5 lineWrite 05 ffffffff 00112233445566778899aabbccddeeff0123456789abcdeffedcba9876543210 -
fullRead5 lineRead 05 0 - 00112233445566778899aabbccddeeff0123456789abcdeffedcba9876543210
wbLane0 wbRead 028 0 - 76543210
wbLane3 wbRead 02b 0 - 01234567
wbLane7 wbRead 02f 0 - 00112233
wbPartial wbWrite 02a 5 11223344 -
wbPartialRead wbRead 02a 0 - 8922cd44
wbPartialLine lineRead 05 0 - 00112233445566778899aabbccddeeff012345678922cd44fedcba9876543210
wbNoSelect wbWrite 02d 0 ffffffff -
wbNoSelectRead wbRead 02d 0 - 8899aabb
randWrite12 lineWrite 12 ffffffff rand -
randRead12 lineRead 12 0 - ref
randLane3 wbRead 093 0 - ref
randLane6 wbRead 096 0 - ref
randPartial12 lineWrite 12 0000ff0f rand -
randPartialRead lineRead 12 0 - ref
randWbWrite wbWrite 097 e rand -
randWbLine lineRead 12 0 - ref
collideRead collide 029 00000060 000000000000000000000000000000000000000000000000aabbccdd00000000 febbcc98
collideStored wbRead 029 0 - febbcc98
collideRand collide 095 ffff0000 rand ref
collideWrite collideRev 02c c 99887766 00112233445566778899aabb9988eeff012345678922cd44febbcc9876543210
collideStoredLine lineRead 05 0 - 00112233445566778899aabb9988eeff012345678922cd44febbcc9876543210
collideRevRand collideRev 091 f rand ref
collideRevRandLine lineRead 12 0 - ref
zeroLine60 lineWrite 60 ffffffff 0 -
b2bWrite0 wbWrite 300 f cafef00d -
b2bWrite1 wbWrite 301 3 12345678 -
b2bRead0 wbRead 300 0 - cafef00d
b2bRead1 wbRead 301 0 - 00005678
b2bRead2 wbRead 302 0 - 00000000
b2bLine lineRead 60 0 - 00000000000000000000000000000000000000000000000000005678cafef00d
topWrite7f lineWrite 7f ffffffff rand -
topLane0 wbRead 3f8 0 - ref
topLane7 wbRead 3ff 0 - ref
byteMask lineWrite 05 80000001 ffeeddccbbaa99887766554433221100ffeeddccbbaa99887766554433221100 -
byteMaskRead lineRead 05 0 - ff112233445566778899aabb9988eeff012345678922cd44febbcc9876543200
byteMaskWord wbRead 02f 0 - ff112233
